// ==== hw/alu_imm_exec.sv ====
// Combinational immediate ALU with sign extension and shifts
`timescale 1ns/1ps
`default_nettype none

module alu_imm_exec (
  input  core_types_pkg::alu_imm_op_t op,
  input  logic [11:0] imm12,
  input  logic [core_types_pkg::xlen-1:0] A_data,
  output logic [core_types_pkg::xlen-1:0] result
);

  logic [core_types_pkg::xlen-1:0] imm_ext;
  logic [4:0] shamt;

  assign imm_ext = {{(core_types_pkg::xlen-12){imm12[11]}}, imm12};
  // Shift amount from low immediate bits, bit 10 selects nothing here
  assign shamt = imm12[4:0];

  always_comb begin
    case (op)
      core_types_pkg::op_addi:  result = A_data + imm_ext;
      core_types_pkg::op_slti:
        result = ($signed(A_data) < $signed(imm_ext)) ? 32'd1 : 32'd0;
      core_types_pkg::op_sltiu: result = (A_data < imm_ext) ? 32'd1 : 32'd0;
      core_types_pkg::op_xori:  result = A_data ^ imm_ext;
      core_types_pkg::op_ori:   result = A_data | imm_ext;
      core_types_pkg::op_andi:  result = A_data & imm_ext;
      core_types_pkg::op_slli:  result = A_data << shamt;
      core_types_pkg::op_srli:  result = A_data >> shamt;
      core_types_pkg::op_srai:  result = $unsigned($signed(A_data) >>> shamt);
      default:                  result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/alu_imm_pipeline.sv ====
// Three-stage immediate ALU pipeline from issue to writeback with stall control
`timescale 1ns/1ps
`default_nettype none

module alu_imm_pipeline (
  input  logic CLK,
  input  logic nRST,
  input  logic issue_valid,
  input  core_types_pkg::alu_imm_op_t issue_op,
  input  logic [11:0] issue_imm12,
  input  logic issue_A_forward,
  input  logic issue_A_is_zero,
  input  logic [core_types_pkg::log_prf_bank_count-1:0] issue_A_bank,
  input  logic [core_types_pkg::log_rows_per_bank-1:0] issue_A_row,
  input  logic [core_types_pkg::log_pr_count-1:0] issue_dest_PR,
  input  logic [core_types_pkg::log_rob_entries-1:0] issue_ROB_index,
  output logic issue_ready,
  output logic A_read_req,
  output logic [core_types_pkg::log_prf_bank_count-1:0] A_read_bank,
  output logic [core_types_pkg::log_rows_per_bank-1:0] A_read_row,
  input  logic A_reg_read_ack,
  input  logic A_reg_read_port,
  input  logic [core_types_pkg::prf_bank_count-1:0][1:0][core_types_pkg::xlen-1:0]
    reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::prf_bank_count-1:0][core_types_pkg::xlen-1:0]
    forward_data_by_bank,
  input  logic WB_ready,
  output logic WB_valid,
  output logic [core_types_pkg::xlen-1:0] WB_data,
  output logic [core_types_pkg::log_pr_count-1:0] WB_PR,
  output logic [core_types_pkg::log_rob_entries-1:0] WB_ROB_index
);

  logic rr_valid, rr_go, rr_done, rr_fwd, rr_zero;
  core_types_pkg::alu_imm_op_t rr_op, ex_op;
  logic [11:0] rr_imm, ex_imm;
  logic [core_types_pkg::log_prf_bank_count-1:0] rr_bank;
  logic [core_types_pkg::log_rows_per_bank-1:0] rr_row;
  logic [core_types_pkg::log_pr_count-1:0] rr_pr, ex_pr;
  logic [core_types_pkg::log_rob_entries-1:0] rr_rob, ex_rob;
  logic ex_valid, ex_free, wb_free;
  logic [core_types_pkg::xlen-1:0] ex_A_data, ex_result;

  // A stage moves only into a free or leaving stage
  assign wb_free = ~WB_valid | WB_ready;
  assign ex_free = ~ex_valid | wb_free;
  assign rr_go = rr_valid & ex_free;
  assign issue_ready = ~rr_valid | rr_done;

  alu_imm_reg_read i_reg_read (
    .CLK(CLK), .nRST(nRST),
    .rr_valid(rr_go), .rr_A_forward(rr_fwd), .rr_A_is_zero(rr_zero),
    .rr_A_bank(rr_bank), .rr_A_row(rr_row),
    .A_read_req(A_read_req), .A_read_bank(A_read_bank), .A_read_row(A_read_row),
    .A_reg_read_ack(A_reg_read_ack), .A_reg_read_port(A_reg_read_port),
    .reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
    .forward_data_by_bank(forward_data_by_bank),
    .rr_done(rr_done), .ex_A_data(ex_A_data)
  );

  alu_imm_exec i_exec (
    .op(ex_op), .imm12(ex_imm), .A_data(ex_A_data), .result(ex_result)
  );

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      rr_valid <= 1'b0;
      ex_valid <= 1'b0;
      WB_valid <= 1'b0;
    end else begin
      if (issue_ready) rr_valid <= issue_valid;
      if (ex_free) ex_valid <= rr_done;
      if (wb_free) WB_valid <= ex_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (issue_ready && issue_valid) begin
      rr_op <= issue_op;
      rr_imm <= issue_imm12;
      rr_fwd <= issue_A_forward;
      rr_zero <= issue_A_is_zero;
      rr_bank <= issue_A_bank;
      rr_row <= issue_A_row;
      rr_pr <= issue_dest_PR;
      rr_rob <= issue_ROB_index;
    end
    if (rr_done) begin
      ex_op <= rr_op;
      ex_imm <= rr_imm;
      ex_pr <= rr_pr;
      ex_rob <= rr_rob;
    end
    // WB frozen while the consumer stalls
    if (wb_free && ex_valid) begin
      WB_data <= ex_result;
      WB_PR <= ex_pr;
      WB_ROB_index <= ex_rob;
    end
  end

  alu_imm_wb_checks i_wb_checks (
    .CLK(CLK), .nRST(nRST),
    .issue_valid(issue_valid), .issue_ready(issue_ready),
    .issue_dest_PR(issue_dest_PR), .issue_ROB_index(issue_ROB_index),
    .WB_ready(WB_ready), .WB_valid(WB_valid), .WB_data(WB_data),
    .WB_PR(WB_PR), .WB_ROB_index(WB_ROB_index)
  );

endmodule

`default_nettype wire

// ==== hw/alu_imm_reg_read.sv ====
// Register-read stage resolving operand A from zero, forwarding or a bank read
`timescale 1ns/1ps
`default_nettype none

module alu_imm_reg_read (
  input  logic CLK,
  input  logic nRST,
  input  logic rr_valid,
  input  logic rr_A_forward,
  input  logic rr_A_is_zero,
  input  logic [core_types_pkg::log_prf_bank_count-1:0] rr_A_bank,
  input  logic [core_types_pkg::log_rows_per_bank-1:0] rr_A_row,
  output logic A_read_req,
  output logic [core_types_pkg::log_prf_bank_count-1:0] A_read_bank,
  output logic [core_types_pkg::log_rows_per_bank-1:0] A_read_row,
  input  logic A_reg_read_ack,
  input  logic A_reg_read_port,
  input  logic [core_types_pkg::prf_bank_count-1:0][1:0][core_types_pkg::xlen-1:0]
    reg_read_data_by_bank_by_port,
  input  logic [core_types_pkg::prf_bank_count-1:0][core_types_pkg::xlen-1:0]
    forward_data_by_bank,
  output logic rr_done,
  output logic [core_types_pkg::xlen-1:0] ex_A_data
);

  logic use_rf;
  logic [core_types_pkg::log_prf_bank_count-1:0] sel_bank;
  logic sel_port;
  logic [core_types_pkg::xlen-1:0] a_q, a_now;

  // Bank read only when operand is neither zero nor forwarded
  assign A_read_req = rr_valid & ~rr_A_is_zero & ~rr_A_forward;
  assign A_read_bank = rr_A_bank;
  assign A_read_row = rr_A_row;
  assign rr_done = rr_valid & (rr_A_is_zero | rr_A_forward | A_reg_read_ack);

  assign a_now = rr_A_is_zero ? '0 : forward_data_by_bank[rr_A_bank];

  // Read data shows up on the acknowledged port one cycle later
  assign ex_A_data = use_rf ? reg_read_data_by_bank_by_port[sel_bank][sel_port] : a_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      use_rf <= 1'b0;
    end else if (rr_done) begin
      use_rf <= A_read_req;
    end else begin
      use_rf <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (rr_done && !A_read_req) begin
      a_q <= a_now;
    end else if (use_rf) begin
      // Keep bank data once the port can be reused by later reads
      a_q <= ex_A_data;
    end
    if (rr_done) begin
      sel_bank <= rr_A_bank;
      sel_port <= A_reg_read_port;
    end
  end

endmodule

`default_nettype wire

// ==== hw/alu_imm_subsystem.sv ====
// Immediate ALU subsystem top joining the pipeline and the physical register file
`timescale 1ns/1ps
`default_nettype none

module alu_imm_subsystem (
  input  logic CLK,
  input  logic nRST,
  input  logic issue_valid,
  input  core_types_pkg::alu_imm_op_t issue_op,
  input  logic [11:0] issue_imm12,
  input  logic issue_A_forward,
  input  logic issue_A_is_zero,
  input  logic [core_types_pkg::log_prf_bank_count-1:0] issue_A_bank,
  input  logic [core_types_pkg::log_rows_per_bank-1:0] issue_A_row,
  input  logic [core_types_pkg::log_pr_count-1:0] issue_dest_PR,
  input  logic [core_types_pkg::log_rob_entries-1:0] issue_ROB_index,
  output logic issue_ready,
  input  logic WB_ready,
  output logic WB_valid,
  output logic [core_types_pkg::xlen-1:0] WB_data,
  output logic [core_types_pkg::log_pr_count-1:0] WB_PR,
  output logic [core_types_pkg::log_rob_entries-1:0] WB_ROB_index,
  input  logic ext_write,
  input  logic [core_types_pkg::log_pr_count-1:0] ext_write_pr,
  input  logic [core_types_pkg::xlen-1:0] ext_write_data,
  input  logic ext_read_valid,
  input  logic [core_types_pkg::log_pr_count-1:0] ext_read_pr,
  output logic [core_types_pkg::xlen-1:0] ext_read_data,
  output logic ext_read_denied
);

  logic A_read_req, A_reg_read_ack, A_reg_read_port;
  logic [core_types_pkg::log_prf_bank_count-1:0] A_read_bank;
  logic [core_types_pkg::log_rows_per_bank-1:0] A_read_row;
  logic [core_types_pkg::prf_bank_count-1:0][1:0][core_types_pkg::xlen-1:0]
    reg_read_data_by_bank_by_port;
  logic [core_types_pkg::prf_bank_count-1:0][core_types_pkg::xlen-1:0] forward_data_by_bank;

  alu_imm_pipeline i_pipeline (
    .CLK(CLK), .nRST(nRST),
    .issue_valid(issue_valid), .issue_op(issue_op), .issue_imm12(issue_imm12),
    .issue_A_forward(issue_A_forward), .issue_A_is_zero(issue_A_is_zero),
    .issue_A_bank(issue_A_bank), .issue_A_row(issue_A_row),
    .issue_dest_PR(issue_dest_PR), .issue_ROB_index(issue_ROB_index),
    .issue_ready(issue_ready),
    .A_read_req(A_read_req), .A_read_bank(A_read_bank), .A_read_row(A_read_row),
    .A_reg_read_ack(A_reg_read_ack), .A_reg_read_port(A_reg_read_port),
    .reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
    .forward_data_by_bank(forward_data_by_bank),
    .WB_ready(WB_ready), .WB_valid(WB_valid), .WB_data(WB_data),
    .WB_PR(WB_PR), .WB_ROB_index(WB_ROB_index)
  );

  phys_reg_file i_phys_reg_file (
    .CLK(CLK), .nRST(nRST),
    .ext_write(ext_write), .ext_write_pr(ext_write_pr), .ext_write_data(ext_write_data),
    .ext_read_valid(ext_read_valid), .ext_read_pr(ext_read_pr),
    .ext_read_data(ext_read_data), .ext_read_denied(ext_read_denied),
    .A_read_req(A_read_req), .A_read_bank(A_read_bank), .A_read_row(A_read_row),
    .A_reg_read_ack(A_reg_read_ack), .A_reg_read_port(A_reg_read_port),
    .reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
    .forward_data_by_bank(forward_data_by_bank)
  );

endmodule

`default_nettype wire

// ==== hw/alu_imm_wb_checks.sv ====
// Writeback stall hold and three-cycle PR and ROB index pass-through assertions
`timescale 1ns/1ps
`default_nettype none

module alu_imm_wb_checks (
  input logic CLK,
  input logic nRST,
  input logic issue_valid,
  input logic issue_ready,
  input logic [core_types_pkg::log_pr_count-1:0] issue_dest_PR,
  input logic [core_types_pkg::log_rob_entries-1:0] issue_ROB_index,
  input logic WB_ready,
  input logic WB_valid,
  input logic [core_types_pkg::xlen-1:0] WB_data,
  input logic [core_types_pkg::log_pr_count-1:0] WB_PR,
  input logic [core_types_pkg::log_rob_entries-1:0] WB_ROB_index
);

  logic [2:0] issue_hist;
  logic [2:0] ready_hist;

  // Last three edges of accepted issues and writeback ready
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      issue_hist <= '0;
      ready_hist <= '0;
    end else begin
      issue_hist <= {issue_hist[1:0], issue_valid & issue_ready};
      ready_hist <= {ready_hist[1:0], WB_ready};
    end
  end

  a_wb_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (WB_valid && !WB_ready) |=>
      ($stable(WB_valid) && $stable(WB_data) && $stable(WB_PR) && $stable(WB_ROB_index)));

  // Unbroken flow means each result left issue three edges ago
  a_wb_pass_through: assert property (@(posedge CLK) disable iff (!nRST)
    (&issue_hist && &ready_hist) |->
      (WB_valid && WB_PR == $past(issue_dest_PR, 3) &&
       WB_ROB_index == $past(issue_ROB_index, 3)));

endmodule

`default_nettype wire

// ==== hw/core_types_pkg.sv ====
// Core sizes, register file geometry and ALU immediate operation codes
`default_nettype none

package core_types_pkg;

  // Register file banking
  localparam int prf_bank_count = 4;
  localparam int log_prf_bank_count = 2;
  localparam int pr_count = 64;
  localparam int log_pr_count = 6;
  localparam int rows_per_bank = 16;
  localparam int log_rows_per_bank = 4;

  localparam int log_rob_entries = 6;
  localparam int xlen = 32;

  // Immediate ALU operations, unlisted codes give a zero result
  typedef enum logic [3:0] {
    op_addi  = 4'd0,
    op_slti  = 4'd1,
    op_sltiu = 4'd2,
    op_xori  = 4'd3,
    op_ori   = 4'd4,
    op_andi  = 4'd5,
    op_slli  = 4'd6,
    op_srli  = 4'd7,
    op_srai  = 4'd8
  } alu_imm_op_t;

endpackage

`default_nettype wire

// ==== hw/phys_reg_file.sv ====
// Banked physical register file with external ports and pipeline read arbitration
`timescale 1ns/1ps
`default_nettype none

module phys_reg_file (
  input  logic CLK,
  input  logic nRST,
  input  logic ext_write,
  input  logic [core_types_pkg::log_pr_count-1:0] ext_write_pr,
  input  logic [core_types_pkg::xlen-1:0] ext_write_data,
  input  logic ext_read_valid,
  input  logic [core_types_pkg::log_pr_count-1:0] ext_read_pr,
  output logic [core_types_pkg::xlen-1:0] ext_read_data,
  output logic ext_read_denied,
  input  logic A_read_req,
  input  logic [core_types_pkg::log_prf_bank_count-1:0] A_read_bank,
  input  logic [core_types_pkg::log_rows_per_bank-1:0] A_read_row,
  output logic A_reg_read_ack,
  output logic A_reg_read_port,
  output logic [core_types_pkg::prf_bank_count-1:0][1:0][core_types_pkg::xlen-1:0]
    reg_read_data_by_bank_by_port,
  output logic [core_types_pkg::prf_bank_count-1:0][core_types_pkg::xlen-1:0]
    forward_data_by_bank
);

  logic [core_types_pkg::xlen-1:0] mem [core_types_pkg::prf_bank_count]
    [core_types_pkg::rows_per_bank];
  logic [core_types_pkg::log_prf_bank_count-1:0] write_bank, ext_bank, ext_bank_q;
  logic [core_types_pkg::log_rows_per_bank-1:0] write_row, ext_row;
  logic ext_grant;
  logic [core_types_pkg::prf_bank_count-1:0][1:0] port_en;
  logic [core_types_pkg::prf_bank_count-1:0][1:0][core_types_pkg::log_rows_per_bank-1:0]
    port_row;

  // Bank is the low PR bits, row the upper ones
  assign write_bank = ext_write_pr[core_types_pkg::log_prf_bank_count-1:0];
  assign write_row = ext_write_pr[core_types_pkg::log_pr_count-1:
                                  core_types_pkg::log_prf_bank_count];
  assign ext_bank = ext_read_pr[core_types_pkg::log_prf_bank_count-1:0];
  assign ext_row = ext_read_pr[core_types_pkg::log_pr_count-1:
                               core_types_pkg::log_prf_bank_count];

  // A written bank serves no reads this cycle
  assign ext_read_denied = ext_read_valid & ext_write & (ext_bank == write_bank);
  assign ext_grant = ext_read_valid & ~ext_read_denied;
  assign A_reg_read_ack = A_read_req & ~(ext_write & (A_read_bank == write_bank));
  // External reader owns port 0, pipeline moves to port 1 on a shared bank
  assign A_reg_read_port = ext_grant & (ext_bank == A_read_bank);

  always_comb begin
    port_en = '0;
    port_row = '0;
    if (ext_grant) begin
      port_en[ext_bank][0] = 1'b1;
      port_row[ext_bank][0] = ext_row;
    end
    if (A_reg_read_ack) begin
      port_en[A_read_bank][A_reg_read_port] = 1'b1;
      port_row[A_read_bank][A_reg_read_port] = A_read_row;
    end
  end

  for (genvar b = 0; b < core_types_pkg::prf_bank_count; b++) begin : g_fwd
    assign forward_data_by_bank[b] =
      (ext_write && write_bank == core_types_pkg::log_prf_bank_count'(b)) ?
      ext_write_data : '0;
  end

  always_ff @(posedge CLK) begin
    if (ext_write) begin
      mem[write_bank][write_row] <= ext_write_data;
    end
    for (int b = 0; b < core_types_pkg::prf_bank_count; b++) begin
      for (int p = 0; p < 2; p++) begin
        if (port_en[b][p]) begin
          reg_read_data_by_bank_by_port[b][p] <= mem[b][port_row[b][p]];
        end
      end
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      ext_bank_q <= '0;
    end else if (ext_grant) begin
      ext_bank_q <= ext_bank;
    end
  end

  assign ext_read_data = reg_read_data_by_bank_by_port[ext_bank_q][0];

  // Both granted readers keep their own row on their own port
  a_port_owner: assert property (@(posedge CLK) disable iff (!nRST)
    (A_reg_read_ack && ext_grant) |->
      (port_row[ext_bank][0] == ext_row &&
       port_row[A_read_bank][A_reg_read_port] == A_read_row));

endmodule

`default_nettype wire

// ==== sim/alu_imm_ref.svh ====
// Reference immediate ALU result function and xorshift random generator
`ifndef alu_imm_ref_svh
`define alu_imm_ref_svh

// Expected result of one immediate operation on operand A
function automatic logic [core_types_pkg::xlen-1:0] alu_imm_expect(
  input logic [3:0] op,
  input logic [11:0] imm12,
  input logic [core_types_pkg::xlen-1:0] a
);
  logic [core_types_pkg::xlen-1:0] imm;
  logic [core_types_pkg::xlen-1:0] sign_bit;
  logic [core_types_pkg::xlen-1:0] fill;
  logic [4:0] sh;
  imm = {{(core_types_pkg::xlen-12){imm12[11]}}, imm12};
  sign_bit = {1'b1, {(core_types_pkg::xlen-1){1'b0}}};
  sh = imm12[4:0];
  // Ones shifted in from the top for a negative arithmetic shift
  fill = a[core_types_pkg::xlen-1] ? ~({core_types_pkg::xlen{1'b1}} >> sh) : '0;
  case (op)
    core_types_pkg::op_addi:  alu_imm_expect = a + imm;
    // Signed order equals unsigned order with both sign bits flipped
    core_types_pkg::op_slti:
      alu_imm_expect = {{(core_types_pkg::xlen-1){1'b0}}, (a ^ sign_bit) < (imm ^ sign_bit)};
    core_types_pkg::op_sltiu:
      alu_imm_expect = {{(core_types_pkg::xlen-1){1'b0}}, a < imm};
    core_types_pkg::op_xori:  alu_imm_expect = a ^ imm;
    core_types_pkg::op_ori:   alu_imm_expect = a | imm;
    core_types_pkg::op_andi:  alu_imm_expect = a & imm;
    core_types_pkg::op_slli:  alu_imm_expect = a << sh;
    core_types_pkg::op_srli:  alu_imm_expect = a >> sh;
    core_types_pkg::op_srai:  alu_imm_expect = (a >> sh) | fill;
    default:                  alu_imm_expect = '0;
  endcase
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

`endif

// ==== sim/alu_imm_tb.sv ====
// Testbench top with stimulus, shadow register file, expected queue, compare and watchdog
`timescale 1ns/1ps
`default_nettype none

module alu_imm_tb;

  `include "alu_imm_ref.svh"

  localparam int n_per_test = 24;
  localparam int n_instr = 6 * n_per_test;
  localparam int watchdog_cycles = 10 + core_types_pkg::pr_count + 40 * n_instr + 4 * n_per_test;

  logic CLK, nRST;
  logic issue_valid, issue_ready, issue_A_forward, issue_A_is_zero;
  core_types_pkg::alu_imm_op_t issue_op;
  logic [11:0] issue_imm12;
  logic [core_types_pkg::log_prf_bank_count-1:0] issue_A_bank;
  logic [core_types_pkg::log_rows_per_bank-1:0] issue_A_row;
  logic [core_types_pkg::log_pr_count-1:0] issue_dest_PR, WB_PR, ext_write_pr, ext_read_pr;
  logic [core_types_pkg::log_rob_entries-1:0] issue_ROB_index, WB_ROB_index;
  logic WB_ready, WB_valid, ext_write, ext_read_valid, ext_read_denied;
  logic [core_types_pkg::xlen-1:0] WB_data, ext_write_data, ext_read_data;

  logic [core_types_pkg::xlen-1:0] shadow [core_types_pkg::pr_count];
  logic [core_types_pkg::xlen-1:0] exp_data_q [$];
  logic [core_types_pkg::log_pr_count-1:0] exp_pr_q [$];
  logic [core_types_pkg::log_rob_entries-1:0] exp_rob_q [$];
  int exp_edge_q [$];
  int exp_latency_q [$];
  int edge_count = 0;
  int issued = 0;
  int retired = 0;
  int wb_edge, wb_latency;
  logic [31:0] rng_state, bp_state;
  logic bp_random = 1'b0;
  logic hold_check = 1'b0;
  logic [core_types_pkg::xlen-1:0] held_data;
  logic [11:0] held_tag;

  tb_clock_gen i_clock_gen (.CLK(CLK));

  alu_imm_subsystem i_alu_imm_subsystem (.*);

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic write_reg(input logic [5:0] pr, input logic [31:0] data);
    ext_write = 1'b1;
    ext_write_pr = pr;
    ext_write_data = data;
    @(posedge CLK);
    #1;
    ext_write = 1'b0;
  endtask

  // Fields of r: op, immediate, operand PR, destination PR
  task automatic issue_one(input logic [31:0] r, input logic zero, input logic fwd,
                           input int latency);
    logic [3:0] op;
    logic [31:0] a, fwd_data;
    op = r[3:0] % 4'd10;
    fwd_data = next_random();
    issue_valid = 1'b1;
    issue_op = core_types_pkg::alu_imm_op_t'(op);
    issue_imm12 = r[15:4];
    issue_A_is_zero = zero;
    issue_A_forward = fwd;
    issue_A_bank = r[17:16];
    issue_A_row = r[21:18];
    issue_dest_PR = r[27:22];
    issue_ROB_index = issue_ROB_index + 1'b1;
    do @(posedge CLK); while (!issue_ready);
    a = zero ? '0 : (fwd ? fwd_data : shadow[r[21:16]]);
    exp_data_q.push_back(alu_imm_expect(op, r[15:4], a));
    exp_pr_q.push_back(issue_dest_PR);
    exp_rob_q.push_back(issue_ROB_index);
    exp_edge_q.push_back(edge_count);
    exp_latency_q.push_back(latency);
    issued++;
    #1;
    issue_valid = 1'b0;
    // Forwarded value is written to the operand bank during RR
    if (fwd) write_reg(r[21:16], fwd_data);
  endtask

  task automatic wait_for_drain();
    do begin
      @(posedge CLK);
      #1;
    end while (exp_data_q.size() != 0);
  endtask

  always @(posedge CLK) edge_count <= edge_count + 1;

  always @(posedge CLK) if (ext_write) shadow[ext_write_pr] <= ext_write_data;

  // Random writeback back-pressure
  always @(posedge CLK) begin
    #1;
    if (bp_random) begin
      bp_state = xorshift32(bp_state);
      WB_ready = bp_state[9];
    end
  end

  always @(posedge CLK) begin : compare
    if (nRST && hold_check) begin
      check_value(WB_valid, 1'b1, "WB_valid under stall");
      check_value(WB_data, held_data, "WB_data under stall");
      check_value({WB_ROB_index, WB_PR}, held_tag, "WB tag under stall");
    end
    hold_check = nRST && WB_valid && !WB_ready;
    held_data = WB_data;
    held_tag = {WB_ROB_index, WB_PR};
    if (nRST && WB_valid && WB_ready) begin
      if (exp_data_q.size() == 0) begin
        $display("Writeback at %0t ns had no issued instruction behind it", $time);
        $display("Simulation failed");
        $fatal(1, "unexpected writeback");
      end else begin
        check_value(WB_data, exp_data_q.pop_front(), "WB_data");
        check_value(WB_PR, exp_pr_q.pop_front(), "WB_PR");
        check_value(WB_ROB_index, exp_rob_q.pop_front(), "WB_ROB_index");
        wb_edge = exp_edge_q.pop_front();
        wb_latency = exp_latency_q.pop_front();
        if (wb_latency != 0) begin
          check_value(edge_count - wb_edge, wb_latency, "issue to writeback edges");
        end
        retired++;
      end
    end
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  initial begin : stimulus
    logic [31:0] r, exp_ext;
    int k;
    nRST = 1'b0;
    issue_valid = 1'b0;
    issue_op = core_types_pkg::op_addi;
    issue_imm12 = '0;
    issue_A_forward = 1'b0;
    issue_A_is_zero = 1'b0;
    issue_A_bank = '0;
    issue_A_row = '0;
    issue_dest_PR = '0;
    issue_ROB_index = '0;
    WB_ready = 1'b1;
    ext_write = 1'b0;
    ext_write_pr = '0;
    ext_write_data = '0;
    ext_read_valid = 1'b0;
    ext_read_pr = '0;
    rng_state = 32'h2586318f;
    bp_state = next_random();
    repeat (10) @(posedge CLK);
    #1;
    nRST = 1'b1;
    check_value(WB_valid, 1'b0, "WB_valid after reset");
    check_value(issue_ready, 1'b1, "issue_ready after reset");
    for (int p = 0; p < core_types_pkg::pr_count; p++) write_reg(p[5:0], next_random());
    // Register operands back to back
    for (int i = 0; i < n_per_test; i++) issue_one(next_random(), 1'b0, 1'b0, 3);
    wait_for_drain();
    for (int i = 0; i < n_per_test; i++) issue_one(next_random(), 1'b1, 1'b0, 3);
    wait_for_drain();
    for (int i = 0; i < n_per_test; i++) issue_one(next_random(), 1'b0, 1'b1, 3);
    wait_for_drain();
    bp_random = 1'b1;
    for (int i = 0; i < n_per_test; i++) begin
      r = next_random();
      issue_one(r, r[31], 1'b0, 0);
    end
    wait_for_drain();
    bp_random = 1'b0;
    WB_ready = 1'b1;
    // Writes to the operand bank hold off the read by one cycle each
    for (int i = 0; i < n_per_test; i++) begin
      r = next_random();
      k = 1 + r[29:28];
      issue_one(r, 1'b0, 1'b0, 3 + k);
      for (int w = 0; w < k; w++) write_reg({r[21:18] + 4'd1, r[17:16]}, next_random());
      wait_for_drain();
    end
    // External read sharing the operand bank
    for (int i = 0; i < n_per_test; i++) begin
      r = next_random();
      issue_one(r, 1'b0, 1'b0, 3);
      ext_read_valid = 1'b1;
      ext_read_pr = {r[31:28], r[17:16]};
      exp_ext = shadow[{r[31:28], r[17:16]}];
      @(negedge CLK);
      check_value(ext_read_denied, 1'b0, "ext_read_denied on shared bank");
      @(posedge CLK);
      #1;
      ext_read_valid = 1'b0;
      check_value(ext_read_data, exp_ext, "ext_read_data on shared bank");
      wait_for_drain();
    end
    // External read against a write, same bank when r[12] is low
    for (int i = 0; i < n_per_test; i++) begin
      r = next_random();
      ext_read_valid = 1'b1;
      ext_read_pr = r[5:0];
      exp_ext = shadow[r[5:0]];
      ext_write = 1'b1;
      ext_write_pr = {r[11:8], r[1:0] + {1'b0, r[12]}};
      ext_write_data = next_random();
      @(negedge CLK);
      check_value(ext_read_denied, !r[12], "ext_read_denied against a write");
      @(posedge CLK);
      #1;
      ext_read_valid = 1'b0;
      ext_write = 1'b0;
      if (r[12]) check_value(ext_read_data, exp_ext, "ext_read_data beside a write");
    end
    wait_for_drain();
    if (retired == issued && issued == n_instr) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Writeback count %0d does not match issue count %0d", retired, issued);
      $display("Simulation failed");
      $fatal(1, "result count mismatch");
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Testbench clock source with an 8 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic CLK
);

  initial begin
    CLK = 1'b0;
    // 4 ns per half period
    forever #4 CLK = ~CLK;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+sim
hw/core_types_pkg.sv
hw/phys_reg_file.sv
hw/alu_imm_reg_read.sv
hw/alu_imm_exec.sv
hw/alu_imm_wb_checks.sv
hw/alu_imm_pipeline.sv
hw/alu_imm_subsystem.sv
sim/tb_clock_gen.sv
sim/alu_imm_tb.sv
